//--- design/sifh_config.svh
`ifndef SIFH_CONFIG_SVH
`define SIFH_CONFIG_SVH

// raw timestamp width from the tdc
`define TS_W 8

// timestamp lsbs folded into one bin
`define BIN_SHIFT 2

// bins per pixel histogram
`define BIN_NUM 16

// pixels sharing one bank
`define PIXEL_NUM 4

// timestamps per pixel in one acquisition
`define DATA_NUM 3

// acquisitions summed into one bank
`define ACQ_NUM 2

// bin counter width, counts saturate at all ones
`define COUNT_W 8

`endif

//--- design/sifh_pkg.sv
`include "sifh_config.svh"

package sifh_pkg;

    // sizes seen by blocks that do not pull in the config header
    localparam int NUM_BINS   = `BIN_NUM;
    localparam int NUM_PIXELS = `PIXEL_NUM;

    // index widths
    localparam int BIN_W   = $clog2(`BIN_NUM);
    localparam int PIXEL_W = $clog2(`PIXEL_NUM);
    localparam int ADDR_W  = $clog2(`PIXEL_NUM * `BIN_NUM);

    // raw timestamp
    typedef logic [`TS_W-1:0] ts_t;
    // histogram bin inside one pixel
    typedef logic [BIN_W-1:0] bin_t;
    // pixel inside one bank
    typedef logic [PIXEL_W-1:0] pixel_t;
    // hits in one bin
    typedef logic [`COUNT_W-1:0] count_t;
    // pixel * BIN_NUM + bin
    typedef logic [ADDR_W-1:0] bank_addr_t;

endpackage

//--- design/hist_bank_if.sv
`timescale 1ns/1ns

interface hist_bank_if
    import sifh_pkg::*;
();

    // read request from the scanner
    logic       rd_en;
    bank_addr_t rd_addr;

    // read return, one cycle after rd_en
    count_t     rd_data;
    logic       rd_valid;

    // one cycle strobe when a bank is full
    logic       bank_ready;

    // histogram side, always serves the idle bank
    modport bank (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid,
        output bank_ready
    );

    // scanner side
    modport reader (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid,
        input  bank_ready
    );

endinterface

//--- design/tdc_bin_mapper.sv
`timescale 1ns/1ns
`include "sifh_config.svh"

module tdc_bin_mapper
    import sifh_pkg::*;
(
    input  logic clk,
    input  logic combin_res,
    input  logic ts_valid,
    input  ts_t  ts,
    input  ts_t  window_offset,
    output logic hit,
    output bin_t hit_bin,
    output logic hit_in_range
);

    // full-width bin index before the range check
    localparam int IDX_W = `TS_W - `BIN_SHIFT;

    logic [`TS_W:0]   diff;
    logic             below;
    logic [IDX_W-1:0] bin_full;
    logic             in_range;

    // extra msb catches the borrow
    assign diff = {1'b0, ts} - {1'b0, window_offset};
    // borrow set means timestamp came before the window
    assign below = diff[`TS_W];
    // drop the sub-bin lsbs
    assign bin_full = diff[`TS_W-1:`BIN_SHIFT];
    // past the last bin counts as out of window too
    assign in_range = !below && (bin_full < IDX_W'(`BIN_NUM));

    // strobe follows ts_valid by one clock
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= 1'b0;
        end else begin
            hit <= ts_valid;
        end
    end

    // bin and range flag captured with each timestamp
    always_ff @(posedge clk) begin
        if (ts_valid) begin
            hit_bin      <= bin_t'(bin_full);
            hit_in_range <= in_range;
        end
    end

    // timestamp and offset must be known when a strobe samples them
    a_ts_known: assert property (
        @(posedge clk) disable iff (!combin_res)
        ts_valid |-> !$isunknown(ts) && !$isunknown(window_offset)
    ) else $error("unknown timestamp or window offset on ts_valid");

endmodule

//--- design/hist_builder.sv
`timescale 1ns/1ns
`include "sifh_config.svh"

module hist_builder
    import sifh_pkg::*;
(
    input  logic      clk,
    input  logic      combin_res,
    input  logic      hit,
    input  bin_t      hit_bin,
    input  logic      hit_in_range,
    hist_bank_if.bank rd,
    output count_t    bin_count,
    output logic      acq_done,
    output logic      bank_sel
);

    localparam int ADDR_NUM = `PIXEL_NUM * `BIN_NUM;
    localparam int SAMPLE_W = $clog2(`DATA_NUM + 1);
    localparam int ACQ_W    = $clog2(`ACQ_NUM + 1);

    // two banks, bank_sel picks the one being filled
    count_t              mem [2][ADDR_NUM];
    // a clear bit means the bin was never written since the bank switch
    logic [ADDR_NUM-1:0] valid_bits [2];

    // nested sample / pixel / acquisition counters
    logic [SAMPLE_W-1:0] sample_cnt;
    pixel_t              pixel_cnt;
    logic [ACQ_W-1:0]    acq_cnt;

    // write-back stage, memory is written one clock after the count
    logic       wb_valid;
    logic       wb_bank;
    bank_addr_t wb_addr;
    count_t     wb_data;

    bank_addr_t wr_addr;
    count_t     old_count;
    count_t     new_count;
    logic       last_sample;
    logic       last_pixel;
    logic       last_acq;
    logic       bank_done;
    logic       bin_hit;
    logic       rd_bank;

    // current pixel's slice plus the bin
    assign wr_addr = bank_addr_t'(pixel_cnt) * bank_addr_t'(`BIN_NUM) + bank_addr_t'(hit_bin);

    assign last_sample = sample_cnt == SAMPLE_W'(`DATA_NUM - 1);
    assign last_pixel  = pixel_cnt == pixel_t'(`PIXEL_NUM - 1);
    assign last_acq    = acq_cnt == ACQ_W'(`ACQ_NUM - 1);

    // every strobe is a sample, only in-range ones touch a bin
    assign bin_hit   = hit && hit_in_range;
    assign bank_done = hit && last_sample && last_pixel && last_acq;

    // reader always gets the bank not being filled
    assign rd_bank       = ~bank_sel;
    assign rd.bank_ready = acq_done;

    // pending write-back wins over the stale memory word
    always_comb begin
        if (wb_valid && (wb_bank == bank_sel) && (wb_addr == wr_addr)) begin
            old_count = wb_data;
        end else begin
            old_count = mem[bank_sel][wr_addr];
        end
    end

    // first hit since the switch starts at 1, then count up and stick at max
    always_comb begin
        if (!valid_bits[bank_sel][wr_addr]) begin
            new_count = count_t'(1);
        end else if (old_count == '1) begin
            new_count = old_count;
        end else begin
            new_count = old_count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sample_cnt    <= '0;
            pixel_cnt     <= '0;
            acq_cnt       <= '0;
            acq_done      <= 1'b0;
            bank_sel      <= 1'b0;
            bin_count     <= '0;
            wb_valid      <= 1'b0;
            valid_bits[0] <= '0;
            valid_bits[1] <= '0;
            rd.rd_valid   <= 1'b0;
        end else begin
            acq_done    <= bank_done;
            wb_valid    <= bin_hit;
            rd.rd_valid <= rd.rd_en;

            // out of range leaves bin_count alone
            if (bin_hit) begin
                valid_bits[bank_sel][wr_addr] <= 1'b1;
                bin_count                     <= new_count;
            end

            // swap banks, the new write bank starts empty
            // old bank keeps its data for the scan
            if (bank_done) begin
                bank_sel              <= ~bank_sel;
                valid_bits[~bank_sel] <= '0;
            end

            // sample -> pixel -> acquisition
            if (hit) begin
                if (last_sample) begin
                    sample_cnt <= '0;
                    if (last_pixel) begin
                        pixel_cnt <= '0;
                        acq_cnt   <= last_acq ? '0 : acq_cnt + 1'b1;
                    end else begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end
                end else begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bin_hit) begin
            wb_bank <= bank_sel;
            wb_addr <= wr_addr;
            wb_data <= new_count;
        end
        // commit last cycle's count
        if (wb_valid) begin
            mem[wb_bank][wb_addr] <= wb_data;
        end
        // unwritten bins read back as zero
        if (rd.rd_en) begin
            rd.rd_data <= valid_bits[rd_bank][rd.rd_addr] ? mem[rd_bank][rd.rd_addr] : '0;
        end
    end

    a_sample_bound: assert property (
        @(posedge clk) disable iff (!combin_res)
        sample_cnt < SAMPLE_W'(`DATA_NUM)
    ) else $error("sample counter ran past DATA_NUM");

    // completion is a single pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!combin_res)
        acq_done |=> !acq_done
    ) else $error("acq_done high for two cycles");

endmodule

//--- design/peak_finder.sv
`timescale 1ns/1ns

module peak_finder
    import sifh_pkg::*;
(
    input  logic        clk,
    input  logic        combin_res,
    hist_bank_if.reader rd,
    output logic        peak_valid,
    output pixel_t      peak_pixel,
    output bin_t        peak_bin,
    output count_t      peak_count,
    output logic        scan_done,
    output logic        overrun
);

    // each pixel takes BIN_NUM reads, one drain and one report
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        REPORT
    } state_t;

    state_t state;
    pixel_t pix;
    // bin being requested
    bin_t   rd_bin;
    // bin whose count is coming back
    bin_t   cmp_bin;
    bin_t   max_bin;
    count_t max_count;
    bin_t   nxt_bin;
    count_t nxt_count;
    logic   last_bin;
    logic   last_pix;
    logic   take;

    assign last_bin = rd_bin == bin_t'(NUM_BINS - 1);
    assign last_pix = pix == pixel_t'(NUM_PIXELS - 1);

    assign rd.rd_en   = state == READ;
    assign rd.rd_addr = bank_addr_t'(pix) * bank_addr_t'(NUM_BINS) + bank_addr_t'(rd_bin);

    // strict greater-than keeps the lower bin on a tie
    assign take      = rd.rd_valid && (rd.rd_data > max_count);
    assign nxt_bin   = take ? cmp_bin : max_bin;
    assign nxt_count = take ? rd.rd_data : max_count;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= IDLE;
            pix        <= '0;
            rd_bin     <= '0;
            cmp_bin    <= '0;
            max_bin    <= '0;
            max_count  <= '0;
            peak_valid <= 1'b0;
            scan_done  <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            scan_done  <= 1'b0;
            max_bin    <= nxt_bin;
            max_count  <= nxt_count;

            // a new bank while busy sets the sticky flag and the scan goes on
            if (rd.bank_ready && (state != IDLE)) begin
                overrun <= 1'b1;
            end

            if (rd.rd_valid) begin
                cmp_bin <= cmp_bin + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (rd.bank_ready) begin
                        state  <= READ;
                        pix    <= '0;
                        rd_bin <= '0;
                    end
                end
                READ: begin
                    rd_bin <= rd_bin + 1'b1;
                    if (last_bin) begin
                        state <= DRAIN;
                    end
                end
                // last return arrives here
                DRAIN: begin
                    peak_valid <= 1'b1;
                    scan_done  <= last_pix;
                    state      <= REPORT;
                end
                // clear the running max for the next pixel
                REPORT: begin
                    max_bin   <= '0;
                    max_count <= '0;
                    cmp_bin   <= '0;
                    rd_bin    <= '0;
                    if (last_pix) begin
                        state <= IDLE;
                    end else begin
                        pix   <= pix + 1'b1;
                        state <= READ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // result latched together with the final compare
    always_ff @(posedge clk) begin
        if (state == DRAIN) begin
            peak_pixel <= pix;
            peak_bin   <= nxt_bin;
            peak_count <= nxt_count;
        end
    end

    // bank returns land only in the cycle after a read request
    a_return_in_read: assert property (
        @(posedge clk) disable iff (!combin_res)
        rd.rd_valid |-> (state == READ || state == DRAIN)
    ) else $error("read data returned outside a pixel read");

endmodule

//--- design/sifh_top.sv
`timescale 1ns/1ns

module sifh_top
    import sifh_pkg::*;
(
    input  logic   clk,
    input  logic   combin_res,
    input  logic   ts_valid,
    input  ts_t    ts,
    input  ts_t    window_offset,
    output count_t bin_count,
    output logic   acq_done,
    output logic   bank_sel,
    output logic   peak_valid,
    output pixel_t peak_pixel,
    output bin_t   peak_bin,
    output count_t peak_count,
    output logic   scan_done,
    output logic   overrun
);

    // mapper to builder
    logic hit;
    bin_t hit_bin;
    logic hit_in_range;

    // idle bank read path
    hist_bank_if bank_if ();

    tdc_bin_mapper u_mapper (
        .clk           (clk),
        .combin_res    (combin_res),
        .ts_valid      (ts_valid),
        .ts            (ts),
        .window_offset (window_offset),
        .hit           (hit),
        .hit_bin       (hit_bin),
        .hit_in_range  (hit_in_range)
    );

    hist_builder u_builder (
        .clk          (clk),
        .combin_res   (combin_res),
        .hit          (hit),
        .hit_bin      (hit_bin),
        .hit_in_range (hit_in_range),
        .rd           (bank_if.bank),
        .bin_count    (bin_count),
        .acq_done     (acq_done),
        .bank_sel     (bank_sel)
    );

    peak_finder u_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .rd         (bank_if.reader),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .scan_done  (scan_done),
        .overrun    (overrun)
    );

endmodule

//--- testbench/tb_sifh.sv
`timescale 1ns/1ns
`include "sifh_config.svh"

module tb_sifh
    import sifh_pkg::*;
();

    localparam int SAMPLES  = `PIXEL_NUM * `DATA_NUM * `ACQ_NUM;
    localparam int SCAN_CYC = `PIXEL_NUM * (`BIN_NUM + 2);
    localparam int CNT_MAX  = (1 << `COUNT_W) - 1;
    localparam int TIMEOUT  = 4 * SCAN_CYC;

    logic   clk = 1'b0;
    logic   combin_res;
    logic   ts_valid;
    ts_t    ts;
    ts_t    window_offset;
    count_t bin_count;
    logic   acq_done;
    logic   bank_sel;
    logic   peak_valid;
    pixel_t peak_pixel;
    bin_t   peak_bin;
    count_t peak_count;
    logic   scan_done;
    logic   overrun;

    // reference model, histogram of the bank being filled
    int     hist [`PIXEL_NUM][`BIN_NUM];
    int     m_sample = 0;
    int     m_pixel = 0;
    int     m_acq = 0;
    logic   m_bank = 1'b0;
    count_t last_count = '0;
    ts_t    cur_offset = '0;
    // expected peaks of the last completed bank
    bin_t   exp_pk_bin [`PIXEL_NUM];
    count_t exp_pk_cnt [`PIXEL_NUM];

    // expectations launched with each strobe, then delayed two clocks
    count_t exp_count = '0;
    logic   exp_done = 1'b0;
    logic   exp_bank = 1'b0;
    logic   vld_d1 = 1'b0;
    logic   vld_d2 = 1'b0;
    count_t cnt_d1 = '0;
    count_t cnt_d2 = '0;
    logic   done_d1 = 1'b0;
    logic   done_d2 = 1'b0;
    logic   bank_d1 = 1'b0;
    logic   bank_d2 = 1'b0;

    // scan tracking
    pixel_t rep_pix = '0;
    int     since_done = 0;
    logic   scan_busy = 1'b0;
    logic   ovr_exp = 1'b0;
    bit     check_peaks = 1'b1;
    bin_t   exp_bin_now;
    count_t exp_cnt_now;

    int     mismatches = 0;
    int     failures = 0;
    bit     ok;

    sifh_top DUT (.*);

    always #50 clk = ~clk;

    assign exp_bin_now = exp_pk_bin[rep_pix];
    assign exp_cnt_now = exp_pk_cnt[rep_pix];

    always @(posedge clk) begin
        vld_d1  <= ts_valid;
        vld_d2  <= vld_d1;
        cnt_d1  <= exp_count;
        cnt_d2  <= cnt_d1;
        done_d1 <= exp_done;
        done_d2 <= done_d1;
        bank_d1 <= exp_bank;
        bank_d2 <= bank_d1;
        // report order and scan length both count from the bank strobe
        if (acq_done) begin
            rep_pix    <= '0;
            since_done <= 1;
        end else begin
            since_done <= since_done + 1;
            if (peak_valid) begin
                rep_pix <= rep_pix + 1'b1;
            end
        end
        // a bank finishing mid scan must set the sticky flag
        if (acq_done && !scan_busy) begin
            scan_busy <= 1'b1;
        end else if (scan_done) begin
            scan_busy <= 1'b0;
        end
        if (acq_done && scan_busy) begin
            ovr_exp <= 1'b1;
        end
    end

    // outputs right after reset release
    reset_chk: assert property (@(posedge clk)
        $rose(combin_res) |-> !DUT.hit && !acq_done && !bank_sel && !peak_valid
            && !scan_done && !overrun)
        else begin
            failures++;
            $display("outputs not at their reset values after reset");
        end

    // every strobe shows on bin_count two clocks later
    count_chk: assert property (@(posedge clk) disable iff (!combin_res)
        vld_d2 |-> bin_count == cnt_d2)
        else begin
            mismatches++;
            $display("Mismatch bin_count: got %h, expected %h",
                $sampled(bin_count), $sampled(cnt_d2));
        end

    // completion after exactly SAMPLES strobes, in range or not
    done_chk: assert property (@(posedge clk) disable iff (!combin_res)
        acq_done == done_d2)
        else begin
            mismatches++;
            $display("Mismatch acq_done: got %h, expected %h",
                $sampled(acq_done), $sampled(done_d2));
        end

    bank_chk: assert property (@(posedge clk) disable iff (!combin_res)
        bank_sel == bank_d2)
        else begin
            mismatches++;
            $display("Mismatch bank_sel: got %h, expected %h",
                $sampled(bank_sel), $sampled(bank_d2));
        end

    toggle_chk: assert property (@(posedge clk) disable iff (!combin_res)
        acq_done |-> bank_sel != $past(bank_sel))
        else begin
            failures++;
            $display("bank_sel did not toggle together with acq_done");
        end

    // peak reports in pixel order
    pix_chk: assert property (@(posedge clk) disable iff (!combin_res)
        (peak_valid && check_peaks) |-> peak_pixel == rep_pix)
        else begin
            mismatches++;
            $display("Mismatch peak_pixel: got %h, expected %h",
                $sampled(peak_pixel), $sampled(rep_pix));
        end

    pk_bin_chk: assert property (@(posedge clk) disable iff (!combin_res)
        (peak_valid && check_peaks) |-> peak_bin == exp_bin_now)
        else begin
            mismatches++;
            $display("Mismatch peak_bin: got %h, expected %h",
                $sampled(peak_bin), $sampled(exp_bin_now));
        end

    pk_cnt_chk: assert property (@(posedge clk) disable iff (!combin_res)
        (peak_valid && check_peaks) |-> peak_count == exp_cnt_now)
        else begin
            mismatches++;
            $display("Mismatch peak_count: got %h, expected %h",
                $sampled(peak_count), $sampled(exp_cnt_now));
        end

    scan_len_chk: assert property (@(posedge clk) disable iff (!combin_res)
        (scan_done && check_peaks) |-> since_done == SCAN_CYC)
        else begin
            mismatches++;
            $display("Mismatch scan_done delay: got %h, expected %h",
                $sampled(since_done), SCAN_CYC);
        end

    scan_all_chk: assert property (@(posedge clk) disable iff (!combin_res)
        (scan_done && check_peaks) |-> rep_pix == pixel_t'(`PIXEL_NUM - 1))
        else begin
            failures++;
            $display("scan_done came before every pixel was reported");
        end

    ovr_chk: assert property (@(posedge clk) disable iff (!combin_res)
        overrun == ovr_exp)
        else begin
            mismatches++;
            $display("Mismatch overrun: got %h, expected %h",
                $sampled(overrun), $sampled(ovr_exp));
        end

    // lowest bin wins a tie, empty pixel gives bin 0 count 0
    function automatic void compute_peaks();
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            exp_pk_bin[p] = '0;
            exp_pk_cnt[p] = '0;
            for (int b = 0; b < `BIN_NUM; b++) begin
                if (hist[p][b] > int'(exp_pk_cnt[p])) begin
                    exp_pk_bin[p] = bin_t'(b);
                    exp_pk_cnt[p] = count_t'(hist[p][b]);
                end
            end
        end
    endfunction

    // binning, saturating count and the sample/pixel/acq walk
    function automatic logic update_model(input ts_t t);
        int diff;
        int b;
        logic done;
        diff = int'(t) - int'(cur_offset);
        done = 1'b0;
        if (diff >= 0 && (diff >> `BIN_SHIFT) < `BIN_NUM) begin
            b = diff >> `BIN_SHIFT;
            if (hist[m_pixel][b] < CNT_MAX) begin
                hist[m_pixel][b]++;
            end
            last_count = count_t'(hist[m_pixel][b]);
        end
        m_sample++;
        if (m_sample == `DATA_NUM) begin
            m_sample = 0;
            m_pixel++;
        end
        if (m_pixel == `PIXEL_NUM) begin
            m_pixel = 0;
            m_acq++;
        end
        if (m_acq == `ACQ_NUM) begin
            m_acq = 0;
            done = 1'b1;
            compute_peaks();
            // next bank starts empty
            m_bank = ~m_bank;
            foreach (hist[p, k]) hist[p][k] = 0;
        end
        return done;
    endfunction

    task automatic drive_hit(input ts_t t);
        logic done;
        done = update_model(t);
        @(posedge clk);
        ts_valid  <= 1'b1;
        ts        <= t;
        exp_count <= last_count;
        exp_done  <= done;
        exp_bank  <= m_bank;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            ts_valid <= 1'b0;
            exp_done <= 1'b0;
        end
    endtask

    task automatic set_offset(input ts_t off);
        cur_offset = off;
        @(posedge clk);
        window_offset <= off;
        ts_valid      <= 1'b0;
        exp_done      <= 1'b0;
    endtask

    // one bank of timestamps spread below, inside and above the window
    task automatic random_bank();
        ts_t t;
        bit  again;
        t = cur_offset;
        for (int i = 0; i < SAMPLES; i++) begin
            // some hits repeat the last one back to back
            again = (i > 0) && ($urandom_range(0, 3) == 0);
            if (!again) begin
                t = cur_offset - 8'd16 + ts_t'($urandom_range(0, 95));
            end
            drive_hit(t);
            idle_cycles(again ? 0 : $urandom_range(0, 3));
        end
    endtask

    task automatic wait_scan_done(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
            idle_cycles(1);
            seen = scan_done;
            n++;
        end
    endtask

    initial begin
        combin_res    = 1'b0;
        ts_valid      = 1'b0;
        ts            = '0;
        window_offset = '0;
        void'($urandom(32'h3d53_5b0c));
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        idle_cycles(2);

        set_offset(8'h40);
        random_bank();
        wait_scan_done(ok);
        if (ok) begin
            set_offset(8'h20);
            random_bank();
            wait_scan_done(ok);
        end
        // two banks without gaps, second lands mid scan
        if (ok) begin
            check_peaks = 1'b0;
            for (int i = 0; i < 2 * SAMPLES; i++) begin
                drive_hit(cur_offset + ts_t'(4 * (i % 3)));
            end
            wait_scan_done(ok);
            idle_cycles(4);
            ovr_set: assert (overrun) else begin
                failures++;
                $display("overrun stayed low after a bank completed during a scan");
            end
        end
        if (!ok) begin
            failures++;
            $display("timed out waiting for scan_done");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/sifh_pkg.sv
design/hist_bank_if.sv
design/tdc_bin_mapper.sv
design/hist_builder.sv
design/peak_finder.sv
design/sifh_top.sv
testbench/tb_sifh.sv

//--- Makefile
TOP = tb_sifh

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module sifh_top

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
